/* core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ------------------------------------------------------------
// core sizes.
// ------------------------------------------------------------
`define CORE_WORD_WIDTH 32
`define CORE_REG_COUNT 64
`define CORE_RESET_VECTOR 32'd0

// one step, doubled when a data word follows.
`define CORE_INSTR_BYTES 4

// compare results land here.
`define CORE_FLAGS_REG 1

`endif

/* corePkg.sv */
`default_nettype none

`include "core_settings.svh"

package corePkg;

  typedef logic [`CORE_WORD_WIDTH-1:0] wordT;
  typedef logic [$clog2(`CORE_REG_COUNT)-1:0] regIndexT;

  // ------------------------------------------------------------
  // opcodes, numbered as in the instruction set.
  // ------------------------------------------------------------
  typedef enum logic [5:0] {
    opMove        = 6'd1,
    opLoadImm     = 6'd2,
    opLoadInd     = 6'd3,
    opLoadDir     = 6'd6,
    opStoreDir    = 6'd7,
    opCmpReg      = 6'd13,
    opCmpImm      = 6'd14,
    opSetEq       = 6'd15,
    opSetNe       = 6'd16,
    opSetLt       = 6'd17,
    opSetGt       = 6'd18,
    opJump        = 6'd19,
    opBrFlagClear = 6'd20,
    opBrFlagSet   = 6'd21,
    opBrZero      = 6'd22,
    opBrNonZero   = 6'd23,
    opAddImm      = 6'd28,
    opAdd         = 6'd29,
    opSubImm      = 6'd30,
    opSub         = 6'd31,
    opInc         = 6'd33,
    opDec         = 6'd34,
    opShl         = 6'd35,
    opShr         = 6'd36,
    opNeg         = 6'd37
  } opCodeT;

  typedef enum logic [1:0] {
    memFault = 2'd0,
    memBusy  = 2'd1,
    memDone  = 2'd2
  } memStatusT;

  typedef enum logic [2:0] {
    memNone,
    fetchInstr,
    fetchData,
    loadWord,
    storeWord
  } memCommandT;

  typedef enum logic [3:0] {
    aluMove, aluPassData, aluAdd, aluSub, aluInc, aluDec, aluShl,
    aluShr, aluNeg, aluSetEq, aluSetNe, aluSetLt, aluSetGt, aluCompare
  } aluOpT;

  typedef enum logic [2:0] {
    branchStep,
    branchAlways,
    branchFlagClear,
    branchFlagSet,
    branchRegZero,
    branchRegNonZero
  } branchT;

  typedef enum logic [1:0] {
    instrFault    = 2'd0,
    dataWordFault = 2'd1,
    accessFault   = 2'd2,
    illegalOp     = 2'd3
  } haltCodeT;

endpackage

`default_nettype wire

/* instructionDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module instructionDecoder (
  input  wire corePkg::opCodeT opCode,
  output logic                 hasDataWord,
  output corePkg::memCommandT  memCommand,
  output corePkg::aluOpT       aluOp,
  output logic                 useImmediate,
  output logic                 regWrite,
  output logic                 writeFlags,
  output logic                 loadResult,
  output corePkg::branchT      branch,
  output logic                 illegal
);

  always_comb begin
    illegal = 1'b0;
    case (opCode)
      corePkg::opMove:                     aluOp = corePkg::aluMove;
      corePkg::opLoadImm:                  aluOp = corePkg::aluPassData;
      corePkg::opCmpReg, corePkg::opCmpImm: aluOp = corePkg::aluCompare;
      corePkg::opSetEq:                    aluOp = corePkg::aluSetEq;
      corePkg::opSetNe:                    aluOp = corePkg::aluSetNe;
      corePkg::opSetLt:                    aluOp = corePkg::aluSetLt;
      corePkg::opSetGt:                    aluOp = corePkg::aluSetGt;
      corePkg::opAddImm, corePkg::opAdd:   aluOp = corePkg::aluAdd;
      corePkg::opSubImm, corePkg::opSub:   aluOp = corePkg::aluSub;
      corePkg::opInc:                      aluOp = corePkg::aluInc;
      corePkg::opDec:                      aluOp = corePkg::aluDec;
      corePkg::opShl:                      aluOp = corePkg::aluShl;
      corePkg::opShr:                      aluOp = corePkg::aluShr;
      corePkg::opNeg:                      aluOp = corePkg::aluNeg;
      // loads, stores and branches leave the ALU unused.
      corePkg::opLoadInd, corePkg::opLoadDir, corePkg::opStoreDir,
      corePkg::opJump, corePkg::opBrFlagClear, corePkg::opBrFlagSet,
      corePkg::opBrZero, corePkg::opBrNonZero: aluOp = corePkg::aluMove;
      default: begin
        aluOp = corePkg::aluMove;
        illegal = 1'b1; // opcode 0 lands here too.
      end
    endcase

    case (opCode)
      corePkg::opLoadInd, corePkg::opLoadDir: memCommand = corePkg::loadWord;
      corePkg::opStoreDir:                    memCommand = corePkg::storeWord;
      default:                                memCommand = corePkg::memNone;
    endcase

    case (opCode)
      corePkg::opJump:        branch = corePkg::branchAlways;
      corePkg::opBrFlagClear: branch = corePkg::branchFlagClear;
      corePkg::opBrFlagSet:   branch = corePkg::branchFlagSet;
      corePkg::opBrZero:      branch = corePkg::branchRegZero;
      corePkg::opBrNonZero:   branch = corePkg::branchRegNonZero;
      default:                branch = corePkg::branchStep;
    endcase

    // second word follows the instruction.
    hasDataWord = opCode inside {corePkg::opLoadImm, corePkg::opLoadDir,
      corePkg::opStoreDir, corePkg::opCmpImm, corePkg::opJump,
      corePkg::opBrFlagClear, corePkg::opBrFlagSet, corePkg::opBrZero,
      corePkg::opBrNonZero, corePkg::opAddImm, corePkg::opSubImm};
    useImmediate = opCode inside {corePkg::opCmpImm, corePkg::opAddImm, corePkg::opSubImm};
    writeFlags = opCode inside {corePkg::opCmpReg, corePkg::opCmpImm};
    loadResult = opCode inside {corePkg::opLoadInd, corePkg::opLoadDir};
    regWrite = !illegal && !(opCode inside {corePkg::opStoreDir, corePkg::opJump,
      corePkg::opBrFlagClear, corePkg::opBrFlagSet, corePkg::opBrZero,
      corePkg::opBrNonZero});
  end

endmodule

`default_nettype wire

/* registerFile.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module registerFile (
  input  wire                    clk,
  input  wire                    reset,
  input  wire corePkg::regIndexT readA,
  input  wire corePkg::regIndexT readB,
  input  wire corePkg::regIndexT readC,
  output corePkg::wordT          valueA,
  output corePkg::wordT          valueB,
  output corePkg::wordT          valueC,
  output corePkg::wordT          flags,
  input  wire                    regWrite,
  input  wire corePkg::regIndexT writeIndex,
  input  wire corePkg::wordT     writeData
);

  corePkg::wordT regs [`CORE_REG_COUNT];

  assign valueA = regs[readA]; // async reads.
  assign valueB = regs[readB];
  assign valueC = regs[readC];
  assign flags = regs[`CORE_FLAGS_REG];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regWrite) begin
      regs[writeIndex] <= writeData;
    end
  end

  // index comes from the decoded instruction word.
  writeIndexKnown: assert property (@(posedge clk) disable iff (reset)
    regWrite |-> !$isunknown(writeIndex));

endmodule

`default_nettype wire

/* integerAlu.sv */
`timescale 1ns/10ps
`default_nettype none

module integerAlu (
  input  wire corePkg::aluOpT aluOp,
  input  wire corePkg::wordT  valueA,
  input  wire corePkg::wordT  valueB,
  input  wire corePkg::wordT  valueC,
  input  wire corePkg::wordT  dataWord,
  input  wire                 useImmediate,
  output corePkg::wordT       result
);

  corePkg::wordT operand;
  corePkg::wordT compareTo;

  assign operand = useImmediate ? dataWord : valueC;
  assign compareTo = useImmediate ? dataWord : valueB; // flag compare is A against this.

  always_comb begin
    case (aluOp)
      corePkg::aluMove:     result = valueB;
      corePkg::aluPassData: result = dataWord;
      corePkg::aluAdd:      result = valueB + operand;
      corePkg::aluSub:      result = valueB - operand;
      corePkg::aluInc:      result = valueA + 1'b1;
      corePkg::aluDec:      result = valueA - 1'b1;
      // full-width shift amount, so 32 and up shift everything out.
      corePkg::aluShl:      result = valueB << operand;
      corePkg::aluShr:      result = valueB >> operand;
      corePkg::aluNeg:      result = -valueB;
      corePkg::aluSetEq:    result = corePkg::wordT'(valueB == operand);
      corePkg::aluSetNe:    result = corePkg::wordT'(valueB != operand);
      corePkg::aluSetLt:    result = corePkg::wordT'(valueB < operand);
      corePkg::aluSetGt:    result = corePkg::wordT'(valueB > operand);
      // bit 2 greater, bit 1 less, bit 0 equal.
      corePkg::aluCompare:
        result = corePkg::wordT'({valueA > compareTo, valueA < compareTo,
                                  valueA == compareTo});
      default:              result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* programCounter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module programCounter (
  input  wire                  clk,
  input  wire                  reset,
  input  wire                  advance,
  input  wire corePkg::branchT branch,
  input  wire                  hasDataWord,
  input  wire corePkg::wordT   flags,
  input  wire corePkg::wordT   valueA,
  input  wire corePkg::wordT   dataWord,
  output corePkg::wordT        ipointer
);

  logic taken;

  always_comb begin
    case (branch)
      corePkg::branchAlways:     taken = 1'b1;
      corePkg::branchFlagClear:  taken = !flags[0];
      corePkg::branchFlagSet:    taken = flags[0];
      corePkg::branchRegZero:    taken = (valueA == '0);
      corePkg::branchRegNonZero: taken = (valueA != '0);
      default:                   taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ipointer <= `CORE_RESET_VECTOR;
    end else if (advance) begin
      if (taken) begin
        ipointer <= dataWord; // target is the data word.
      end else begin
        ipointer <= ipointer + (hasDataWord ? 2 * `CORE_INSTR_BYTES : `CORE_INSTR_BYTES);
      end
    end
  end

endmodule

`default_nettype wire

/* memoryPort.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module memoryPort (
  input  wire                      clk,
  input  wire                      reset,
  input  wire corePkg::memCommandT memCommand,
  input  wire corePkg::wordT       ipointer,
  input  wire corePkg::wordT       storeValue,
  input  wire corePkg::wordT       loadAddress,
  input  wire corePkg::wordT       ramIn,
  input  wire corePkg::memStatusT  mcStatus,
  output corePkg::wordT            ramAddress,
  output corePkg::wordT            ramOut,
  output logic                     readReq,
  output logic                     writeReq,
  output corePkg::wordT            instrWord,
  output corePkg::wordT            dataWord,
  output corePkg::wordT            loadValue,
  output logic                     memDone,
  output logic                     memFault
);

  corePkg::memCommandT lastCommand;
  logic pending; // strobe sent, answer not yet seen.

  // status only counts while a request is outstanding.
  assign memDone = pending && (mcStatus == corePkg::memDone);
  assign memFault = pending && (mcStatus == corePkg::memFault);

  // ------------------------------------------------------------
  // strobes and request tracking.
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      readReq <= 1'b0;
      writeReq <= 1'b0;
      pending <= 1'b0;
      lastCommand <= corePkg::memNone;
    end else begin
      readReq <= memCommand inside {corePkg::fetchInstr, corePkg::fetchData, corePkg::loadWord};
      writeReq <= (memCommand == corePkg::storeWord);
      if (memCommand != corePkg::memNone) begin
        lastCommand <= memCommand;
      end
      if (readReq || writeReq) begin
        pending <= 1'b1;
      end else if (memDone || memFault) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    case (memCommand)
      corePkg::fetchInstr: ramAddress <= ipointer;
      corePkg::fetchData:  ramAddress <= ipointer + `CORE_INSTR_BYTES;
      corePkg::loadWord:   ramAddress <= loadAddress;
      corePkg::storeWord: begin
        ramAddress <= loadAddress;
        ramOut <= storeValue;
      end
      default: ;
    endcase
    if (memDone) begin
      case (lastCommand)
        corePkg::fetchInstr: instrWord <= ramIn;
        corePkg::fetchData:  dataWord <= ramIn;
        corePkg::loadWord:   loadValue <= ramIn;
        default: ;
      endcase
    end
  end

  strobesExclusive: assert property (@(posedge clk) disable iff (reset)
    !(readReq && writeReq));
  strobeOneCycle: assert property (@(posedge clk) disable iff (reset)
    (readReq || writeReq) |=> !(readReq || writeReq));

endmodule

`default_nettype wire

/* coreControl.sv */
`timescale 1ns/10ps
`default_nettype none

module coreControl (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      hasDataWord,
  input  wire                      illegal,
  input  wire corePkg::memCommandT memCommandIn,
  input  wire                      memDone,
  input  wire                      memFault,
  output corePkg::memCommandT      memCommand,
  output logic                     advance,
  output logic                     regWriteEnable,
  output logic                     halted,
  output corePkg::haltCodeT        haltCode,
  output corePkg::wordT            haltData,
  input  wire corePkg::wordT       faultAddress
);

  typedef enum logic [2:0] {
    stFetch,
    stWaitInstr,
    stReadOperands,
    stWaitData,
    stAccess,
    stWaitAccess,
    stExecute,
    stHalt
  } stateT;

  stateT state;
  logic needsAccess;

  assign needsAccess = (memCommandIn != corePkg::memNone);
  assign advance = (state == stExecute);
  assign regWriteEnable = (state == stExecute);
  assign halted = (state == stHalt);

  // one-cycle commands, strobe follows a cycle later.
  always_comb begin
    case (state)
      stFetch:        memCommand = corePkg::fetchInstr;
      stReadOperands: memCommand = (hasDataWord && !illegal) ? corePkg::fetchData : corePkg::memNone;
      stAccess:       memCommand = memCommandIn;
      default:        memCommand = corePkg::memNone;
    endcase
  end

  // ------------------------------------------------------------
  // instruction sequencing.
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= stFetch;
    end else begin
      case (state)
        stFetch: state <= stWaitInstr;
        stWaitInstr: begin
          if (memDone) state <= stReadOperands;
          else if (memFault) state <= stHalt;
        end
        stReadOperands: begin
          if (illegal) state <= stHalt;
          else if (hasDataWord) state <= stWaitData;
          else if (needsAccess) state <= stAccess;
          else state <= stExecute;
        end
        stWaitData: begin
          if (memDone) state <= needsAccess ? stAccess : stExecute;
          else if (memFault) state <= stHalt;
        end
        stAccess: state <= stWaitAccess;
        stWaitAccess: begin
          if (memDone) state <= stExecute;
          else if (memFault) state <= stHalt;
        end
        stExecute: state <= stFetch;
        default: state <= stHalt; // stays until reset.
      endcase
    end
  end

  // halt info, faultAddress is the last request address.
  always_ff @(posedge clk) begin
    if (memFault) begin
      haltData <= faultAddress;
      case (state)
        stWaitInstr: haltCode <= corePkg::instrFault;
        stWaitData:  haltCode <= corePkg::dataWordFault;
        default:     haltCode <= corePkg::accessFault;
      endcase
    end else if (state == stReadOperands && illegal) begin
      haltCode <= corePkg::illegalOp;
      haltData <= faultAddress; // still the fetch address here.
    end
  end

  haltSticky: assert property (@(posedge clk) $fell(halted) |-> $past(reset));

endmodule

`default_nettype wire

/* integerCore.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module integerCore (
  input  wire                     clk,
  input  wire                     reset,
  input  wire corePkg::wordT      ramIn,
  input  wire corePkg::memStatusT mcStatus,
  output corePkg::wordT           ramAddress,
  output corePkg::wordT           ramOut,
  output logic                    readReq,
  output logic                    writeReq,
  output corePkg::wordT           ipointer,
  output logic                    halted,
  output corePkg::haltCodeT       haltCode,
  output corePkg::wordT           haltData
);

  corePkg::wordT instrWord, dataWord, loadValue;
  corePkg::wordT valueA, valueB, valueC, flags;
  corePkg::wordT aluResult, writeData, loadAddress;
  corePkg::regIndexT writeIndex;
  corePkg::opCodeT opCode;
  corePkg::memCommandT decodedCommand, memCommand;
  corePkg::aluOpT aluOp;
  corePkg::branchT branch;
  logic hasDataWord, useImmediate, regWrite, writeFlags, loadResult, illegal;
  logic memDone, memFault, advance, regWriteEnable;

  // opcode in bits 5..0, fields A, B, C in bytes 1..3.
  assign opCode = corePkg::opCodeT'(instrWord[5:0]);
  assign writeIndex = writeFlags ? corePkg::regIndexT'(`CORE_FLAGS_REG) : instrWord[13:8];
  assign writeData = loadResult ? loadValue : aluResult;
  assign loadAddress = hasDataWord ? dataWord : valueB; // direct or indirect.

  instructionDecoder u_decoder (
    .opCode(opCode), .hasDataWord(hasDataWord), .memCommand(decodedCommand),
    .aluOp(aluOp), .useImmediate(useImmediate), .regWrite(regWrite),
    .writeFlags(writeFlags), .loadResult(loadResult), .branch(branch),
    .illegal(illegal)
  );

  registerFile u_registers (
    .clk(clk), .reset(reset),
    .readA(instrWord[13:8]), .readB(instrWord[21:16]), .readC(instrWord[29:24]),
    .valueA(valueA), .valueB(valueB), .valueC(valueC), .flags(flags),
    .regWrite(regWrite && regWriteEnable), .writeIndex(writeIndex),
    .writeData(writeData)
  );

  integerAlu u_alu (
    .aluOp(aluOp), .valueA(valueA), .valueB(valueB), .valueC(valueC),
    .dataWord(dataWord), .useImmediate(useImmediate), .result(aluResult)
  );

  programCounter u_pc (
    .clk(clk), .reset(reset), .advance(advance), .branch(branch),
    .hasDataWord(hasDataWord), .flags(flags), .valueA(valueA),
    .dataWord(dataWord), .ipointer(ipointer)
  );

  memoryPort u_memPort (
    .clk(clk), .reset(reset), .memCommand(memCommand), .ipointer(ipointer),
    .storeValue(valueB), .loadAddress(loadAddress), .ramIn(ramIn),
    .mcStatus(mcStatus), .ramAddress(ramAddress), .ramOut(ramOut),
    .readReq(readReq), .writeReq(writeReq), .instrWord(instrWord),
    .dataWord(dataWord), .loadValue(loadValue), .memDone(memDone),
    .memFault(memFault)
  );

  coreControl u_control (
    .clk(clk), .reset(reset), .hasDataWord(hasDataWord), .illegal(illegal),
    .memCommandIn(decodedCommand), .memDone(memDone), .memFault(memFault),
    .memCommand(memCommand), .advance(advance), .regWriteEnable(regWriteEnable),
    .halted(halted), .haltCode(haltCode), .haltData(haltData),
    .faultAddress(ramAddress)
  );

endmodule

`default_nettype wire

/* tbIntegerCore.sv */
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module tbIntegerCore;

  localparam int memWords = 256;
  localparam int watchdogNs = 5 * 200 * 16 * 40; // tests x instructions x cycles x period.
  localparam corePkg::wordT resultBase = 32'h200;

  logic clk = 1'b0;
  logic reset = 1'b1;
  corePkg::wordT ramIn = '0;
  corePkg::memStatusT mcStatus = corePkg::memBusy;
  corePkg::wordT ramAddress, ramOut, ipointer, haltData;
  logic readReq, writeReq, halted;
  corePkg::haltCodeT haltCode;

  corePkg::wordT mem [memWords];
  corePkg::wordT latencyState = 32'd79;
  corePkg::wordT operandState = 32'd79;
  corePkg::wordT reqAddress, reqData;
  logic reqWrite = 1'b0;
  int waitLeft = 0;
  int progIndex = 0;

  integerCore i_dut (
    .clk(clk), .reset(reset), .ramIn(ramIn), .mcStatus(mcStatus),
    .ramAddress(ramAddress), .ramOut(ramOut), .readReq(readReq),
    .writeReq(writeReq), .ipointer(ipointer), .halted(halted),
    .haltCode(haltCode), .haltData(haltData)
  );

  always #20 clk = ~clk;

  function automatic corePkg::wordT xorshift(input corePkg::wordT x);
    corePkg::wordT v;
    v = x ^ (x << 13);
    v = v ^ (v >> 17);
    return v ^ (v << 5);
  endfunction

  function automatic corePkg::wordT nextOperand();
    operandState = xorshift(operandState);
    return operandState;
  endfunction

  // ------------------------------------------------------------
  // memory model answering 1 to 4 cycles after a strobe.
  // ------------------------------------------------------------
  task automatic answerRequest();
    if (reqAddress >= memWords * `CORE_INSTR_BYTES) begin
      mcStatus = corePkg::memFault;
    end else if (reqWrite) begin
      mem[reqAddress / `CORE_INSTR_BYTES] = reqData;
      mcStatus = corePkg::memDone;
    end else begin
      ramIn = mem[reqAddress / `CORE_INSTR_BYTES];
      mcStatus = corePkg::memDone;
    end
  endtask

  always begin
    @(posedge clk);
    #2;
    mcStatus = corePkg::memBusy; // idle and waiting look the same.
    if (waitLeft > 0) begin
      waitLeft--;
      if (waitLeft == 0) begin
        answerRequest();
      end
    end else if (readReq || writeReq) begin
      reqAddress = ramAddress;
      reqData = ramOut;
      reqWrite = writeReq;
      latencyState = xorshift(latencyState);
      waitLeft = 1 + int'(latencyState % 4);
    end
  end

  initial begin
    #(watchdogNs);
    failRun("core never halted before the watchdog expired");
  end

  // ------------------------------------------------------------
  // program building and run control.
  // ------------------------------------------------------------
  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "simulation stopped at first error");
  endtask

  function automatic corePkg::wordT instr(input corePkg::opCodeT op, input int a,
                                          input int b, input int c);
    return {c[7:0], b[7:0], a[7:0], 2'b00, op};
  endfunction

  function automatic corePkg::wordT here();
    return corePkg::wordT'(progIndex * `CORE_INSTR_BYTES);
  endfunction

  function automatic corePkg::wordT storedAt(input corePkg::wordT address);
    return mem[address / `CORE_INSTR_BYTES];
  endfunction

  task automatic emit(input corePkg::wordT word);
    mem[progIndex] = word;
    progIndex++;
  endtask

  task automatic emitLoadImm(input int a, input corePkg::wordT value);
    emit(instr(corePkg::opLoadImm, a, 0, 0));
    emit(value);
  endtask

  task automatic emitStore(input int b, input corePkg::wordT address);
    emit(instr(corePkg::opStoreDir, 0, b, 0));
    emit(address);
  endtask

  // target word is patched once the label is known.
  task automatic emitBranch(input corePkg::opCodeT op, input int a, output int targetSlot);
    emit(instr(op, a, 0, 0));
    targetSlot = progIndex;
    emit('0);
  endtask

  task automatic beginReset();
    @(posedge clk);
    #2;
    reset = 1'b1;
    for (int i = 0; i < memWords; i++) begin
      mem[i] = '0; // opcode 0 halts any program.
    end
    progIndex = 0;
  endtask

  task automatic runToHalt();
    repeat (4) @(posedge clk);
    #2;
    reset = 1'b0;
    @(negedge clk);
    while (!halted) @(negedge clk);
    repeat (8) begin
      @(negedge clk);
      if (readReq || writeReq) begin
        failRun("memory strobe seen after the core halted");
      end
    end
  endtask

  task automatic checkWord(input string name, input corePkg::wordT actual,
                           input corePkg::wordT expected);
    if (actual !== expected) begin
      failRun($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, actual,
                        expected));
    end
  endtask

  task automatic checkHalt(input corePkg::haltCodeT expCode, input corePkg::wordT expData);
    corePkg::haltCodeT code;
    code = haltCode;
    if (code !== expCode) begin
      failRun($sformatf("Mismatch at %0t: haltCode is %s, expected %s", $time,
                        code.name(), expCode.name()));
    end
    checkWord("haltData", haltData, expData);
  endtask

  // ------------------------------------------------------------
  // directed tests.
  // ------------------------------------------------------------
  task automatic loadImmediateStore();
    corePkg::wordT value;
    corePkg::wordT haltAt;
    value = nextOperand();
    beginReset();
    emitLoadImm(5, value);
    emitStore(5, resultBase);
    haltAt = here();
    runToHalt();
    checkWord("stored immediate", storedAt(resultBase), value);
    checkHalt(corePkg::illegalOp, haltAt);
    checkWord("ipointer", ipointer, haltAt);
  endtask

  task automatic aluResults();
    corePkg::wordT x, y, k, s, haltAt;
    corePkg::wordT expected [14];
    x = nextOperand();
    y = nextOperand();
    k = nextOperand();
    s = nextOperand() % 40; // sometimes 32 or more.
    beginReset();
    emitLoadImm(2, x);
    emitLoadImm(3, y);
    emitLoadImm(4, s);
    emitLoadImm(5, 32'd35);
    emit(instr(corePkg::opAdd, 10, 2, 3));
    emit(instr(corePkg::opSub, 11, 2, 3));
    emit(instr(corePkg::opAddImm, 12, 2, 0));
    emit(k);
    emit(instr(corePkg::opSubImm, 13, 2, 0));
    emit(k);
    emit(instr(corePkg::opMove, 14, 2, 0));
    emit(instr(corePkg::opInc, 14, 0, 0));
    emit(instr(corePkg::opMove, 15, 3, 0));
    emit(instr(corePkg::opDec, 15, 0, 0));
    emit(instr(corePkg::opShl, 16, 2, 4));
    emit(instr(corePkg::opShr, 17, 2, 4));
    emit(instr(corePkg::opNeg, 18, 3, 0));
    emit(instr(corePkg::opSetEq, 19, 2, 2));
    emit(instr(corePkg::opSetNe, 20, 2, 3));
    emit(instr(corePkg::opSetLt, 21, 2, 3));
    emit(instr(corePkg::opSetGt, 22, 2, 3));
    emit(instr(corePkg::opShl, 23, 2, 5));
    for (int i = 0; i < 14; i++) begin
      emitStore(10 + i, resultBase + 4 * i);
    end
    haltAt = here();
    expected[0] = x + y;
    expected[1] = x - y;
    expected[2] = x + k;
    expected[3] = x - k;
    expected[4] = x + 32'd1;
    expected[5] = y - 32'd1;
    expected[6] = (s >= 32) ? '0 : x << s;
    expected[7] = (s >= 32) ? '0 : x >> s;
    expected[8] = 32'd0 - y;
    expected[9] = 32'd1;
    expected[10] = (x != y) ? 32'd1 : 32'd0;
    expected[11] = (x < y) ? 32'd1 : 32'd0;
    expected[12] = (x > y) ? 32'd1 : 32'd0;
    expected[13] = '0; // shift by 35.
    runToHalt();
    for (int i = 0; i < 14; i++) begin
      checkWord($sformatf("alu result %0d", i), storedAt(resultBase + 4 * i), expected[i]);
    end
    checkHalt(corePkg::illegalOp, haltAt);
    checkWord("ipointer", ipointer, haltAt);
  endtask

  task automatic branchLoop();
    corePkg::wordT loopCount, loopAt, haltAt;
    corePkg::wordT expected [6];
    int slot;
    int storeRegs [6];
    loopCount = 2 + nextOperand() % 6;
    storeRegs = '{3, 6, 7, 8, 9, 10};
    beginReset();
    emitLoadImm(2, loopCount);
    loopAt = here();
    emit(instr(corePkg::opInc, 3, 0, 0));
    emit(instr(corePkg::opDec, 2, 0, 0));
    emitBranch(corePkg::opBrNonZero, 2, slot);
    mem[slot] = loopAt;
    emitBranch(corePkg::opBrZero, 2, slot);
    emitLoadImm(8, 32'hbad);
    mem[slot] = here();
    emit(instr(corePkg::opCmpImm, 3, 0, 0));
    emit(loopCount); // equal sets flag bit 0.
    emitBranch(corePkg::opBrFlagSet, 0, slot);
    emitLoadImm(9, 32'hbad);
    mem[slot] = here();
    emit(instr(corePkg::opMove, 6, 1, 0));
    emit(instr(corePkg::opCmpReg, 3, 2, 0)); // count against zero.
    emitBranch(corePkg::opBrFlagClear, 0, slot);
    emitLoadImm(10, 32'hbad);
    mem[slot] = here();
    emit(instr(corePkg::opMove, 7, 1, 0));
    for (int i = 0; i < 6; i++) begin
      emitStore(storeRegs[i], resultBase + 4 * i);
    end
    haltAt = here();
    expected = '{loopCount, 32'd1, 32'd4, 32'd0, 32'd0, 32'd0};
    runToHalt();
    for (int i = 0; i < 6; i++) begin
      checkWord($sformatf("branch result r%0d", storeRegs[i]), storedAt(resultBase + 4 * i),
                expected[i]);
    end
    checkHalt(corePkg::illegalOp, haltAt);
    checkWord("ipointer", ipointer, haltAt);
  endtask

  task automatic copyWords();
    corePkg::wordT first, second, haltAt;
    first = nextOperand();
    second = nextOperand();
    beginReset();
    mem[32'h300 / `CORE_INSTR_BYTES] = first;
    mem[32'h304 / `CORE_INSTR_BYTES] = second;
    emit(instr(corePkg::opLoadDir, 5, 0, 0));
    emit(32'h300);
    emitStore(5, 32'h380);
    emitLoadImm(6, 32'h304);
    emit(instr(corePkg::opLoadInd, 7, 6, 0));
    emitStore(7, 32'h384);
    haltAt = here();
    runToHalt();
    checkWord("direct copy", storedAt(32'h380), first);
    checkWord("indirect copy", storedAt(32'h384), second);
    checkHalt(corePkg::illegalOp, haltAt);
    checkWord("ipointer", ipointer, haltAt);
  endtask

  task automatic faultHalts();
    beginReset();
    emit(instr(corePkg::opLoadDir, 5, 0, 0));
    emit(32'h1000);
    runToHalt();
    checkHalt(corePkg::accessFault, 32'h1000);
    checkWord("ipointer", ipointer, 32'h0);
    beginReset();
    emit(instr(corePkg::opJump, 0, 0, 0));
    emit(32'h2000);
    runToHalt();
    checkHalt(corePkg::instrFault, 32'h2000);
    checkWord("ipointer", ipointer, 32'h2000);
    // last word holds a load immediate whose data word is past the array.
    beginReset();
    emit(instr(corePkg::opJump, 0, 0, 0));
    emit(32'h3fc);
    mem[memWords - 1] = instr(corePkg::opLoadImm, 5, 0, 0);
    runToHalt();
    checkHalt(corePkg::dataWordFault, 32'h400);
    checkWord("ipointer", ipointer, 32'h3fc);
  endtask

  initial begin
    loadImmediateStore();
    aluResults();
    branchLoop();
    copyWords();
    faultHalts();
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
corePkg.sv
instructionDecoder.sv
registerFile.sv
integerAlu.sv
programCounter.sv
memoryPort.sv
coreControl.sv
integerCore.sv
tbIntegerCore.sv

/* Makefile */
SOURCES := $(shell grep -v '^+' flist.f) core_settings.svh

obj_dir/VtbIntegerCore: flist.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module tbIntegerCore -f flist.f

run: obj_dir/VtbIntegerCore
	@out="$$(./obj_dir/VtbIntegerCore)"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

.PHONY: run clean
